/* design/cpu_pkg.sv */
package cpu_pkg;

    // ========================================
    // isa
    // ========================================

    typedef enum logic [1:0] {
        op_jmp = 2'b00,
        op_lod = 2'b01,
        op_str = 2'b10,
        op_add = 2'b11
    } op_e;

    typedef struct packed {
        op_e        op;
        logic [5:0] target;
    } jmp_fmt_t;

    typedef struct packed {
        op_e        op;
        logic       reg_sel;  // 0 = a, 1 = b
        logic [4:0] addr;     // offset into data window
    } mem_fmt_t;

    typedef union packed {
        jmp_fmt_t jmp_fmt;
        mem_fmt_t mem_fmt;
    } insn_u;

    // ========================================
    // memory channel
    // ========================================

    localparam logic [7:0] DATA_BASE = 8'hE0;
    localparam int PROG_WORDS = 64;
    localparam int MEM_CREDITS = 2;  // memory request queue depth
    localparam int CREDIT_W = $clog2(MEM_CREDITS + 1);

    typedef struct packed {
        logic       valid;
        logic       we;
        logic [7:0] addr;
        logic [7:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic       valid;   // rdata present
        logic       credit;  // one queue slot freed
        logic [7:0] rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        s_fetch,
        s_wait_insn,
        s_decode,
        s_exec,
        s_wait_data,
        s_write
    } cpu_state_e;

endpackage

/* design/cpu_sequencer.sv */
`timescale 1ns/1ps

module cpu_sequencer (
    input  logic           clk,
    input  logic           rst,
    input  logic           issued,
    input  logic           rd_valid,
    input  logic [7:0]     rd_data,
    output logic           issue_fetch,
    output logic           issue_data,
    output logic           data_we,
    output logic           pc_inc,
    output logic           pc_load,
    output logic           reg_write,
    output cpu_pkg::insn_u insn
);
    import cpu_pkg::*;

    cpu_state_e state;
    cpu_state_e state_nxt;
    logic [1:0] rd_pending;  // reads issued, data not yet back
    logic       rd_issue;

    // ========================================
    // state machine
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= s_fetch;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            s_fetch: begin
                if (issued) state_nxt = s_wait_insn;
            end
            s_wait_insn: begin
                if (rd_valid) state_nxt = s_decode;
            end
            s_decode: begin
                state_nxt = (insn.jmp_fmt.op == op_jmp) ? s_fetch : s_exec;
            end
            s_exec: begin
                if (insn.mem_fmt.op == op_add) begin
                    state_nxt = s_write;
                end else if (issued) begin
                    // str is done once the request leaves
                    state_nxt = (insn.mem_fmt.op == op_lod) ? s_wait_data : s_fetch;
                end
            end
            s_wait_data: begin
                if (rd_valid) state_nxt = s_fetch;
            end
            s_write: state_nxt = s_fetch;
            default: state_nxt = s_fetch;
        endcase
    end

    assign issue_fetch = (state == s_fetch);
    assign issue_data  = (state == s_exec) && (insn.mem_fmt.op inside {op_lod, op_str});
    assign data_we     = (state == s_exec) && (insn.mem_fmt.op == op_str);
    assign pc_inc      = (state == s_wait_insn) && rd_valid;
    assign pc_load     = (state == s_decode) && (insn.jmp_fmt.op == op_jmp);
    assign reg_write   = (state == s_write) || ((state == s_wait_data) && rd_valid);

    // instruction word, held through exec
    always_ff @(posedge clk) begin
        if (pc_inc) insn <= rd_data;
    end

    // ========================================
    // outstanding reads
    // ========================================

    assign rd_issue = issued && !data_we;

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_pending <= 2'd0;
        end else begin
            case ({rd_issue, rd_valid})
                2'b10:   rd_pending <= rd_pending + 2'd1;
                2'b01:   rd_pending <= rd_pending - 2'd1;
                default: rd_pending <= rd_pending;
            endcase
        end
    end

    a_rd_expected: assert property (@(posedge clk) disable iff (!rst)
        rd_valid |-> rd_pending != 2'd0)
        else $error("read data with no read outstanding in %s", state.name());

endmodule

/* design/program_counter.sv */
`timescale 1ns/1ps

module program_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       inc,
    input  logic       load,
    input  logic [5:0] target,
    output logic [7:0] pc
);
    logic [5:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            cnt <= 6'd0;
        end else if (load) begin  // jmp beats increment
            cnt <= target;
        end else if (inc) begin
            cnt <= cnt + 6'd1;  // wraps at 64
        end
    end

    assign pc = {2'b00, cnt};  // program region only

endmodule

/* design/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           reg_write,
    input  cpu_pkg::insn_u insn,
    input  logic [7:0]     rd_data,
    output logic [7:0]     store_data
);
    import cpu_pkg::*;

    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] sum;
    logic [7:0] wr_val;

    // ========================================
    // datapath
    // ========================================

    assign sum    = a + b;  // wraps mod 256
    assign wr_val = (insn.mem_fmt.op == op_lod) ? rd_data : sum;

    always_ff @(posedge clk) begin
        if (!rst) begin
            a <= 8'd0;
            b <= 8'd0;
        end else if (reg_write) begin
            if (insn.mem_fmt.reg_sel) begin
                b <= wr_val;
            end else begin
                a <= wr_val;
            end
        end
    end

    assign store_data = insn.mem_fmt.reg_sel ? b : a;

    // only lod and add write back
    a_wb_op: assert property (@(posedge clk) disable iff (!rst)
        reg_write |-> insn.mem_fmt.op inside {op_lod, op_add})
        else $error("register write for opcode %s", insn.mem_fmt.op.name());

endmodule

/* design/mem_port.sv */
`timescale 1ns/1ps

module mem_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_fetch,
    input  logic              issue_data,
    input  logic              data_we,
    input  logic [7:0]        pc,
    input  logic [7:0]        store_data,
    input  logic [4:0]        data_addr,
    input  cpu_pkg::mem_rsp_t rsp,
    output cpu_pkg::mem_req_t req,
    output logic              issued,
    output logic              rd_valid,
    output logic [7:0]        rd_data
);
    import cpu_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic                grant;

    // ========================================
    // credits
    // ========================================

    assign grant = (issue_fetch || issue_data) && (credits != '0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            credits <= CREDIT_W'(MEM_CREDITS);
        end else begin
            case ({grant, rsp.credit})
                2'b10:   credits <= credits - CREDIT_W'(1);
                2'b01:   credits <= credits + CREDIT_W'(1);
                default: credits <= credits;  // spend and return cancel
            endcase
        end
    end

    // ========================================
    // request register
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= grant;
            if (grant) begin
                if (issue_data) begin  // data before fetch
                    req.we    <= data_we;
                    req.addr  <= DATA_BASE + {3'b000, data_addr};
                    req.wdata <= store_data;
                end else begin
                    req.we    <= 1'b0;
                    req.addr  <= pc;
                    req.wdata <= 8'd0;
                end
            end
        end
    end

    assign issued   = grant;
    assign rd_valid = rsp.valid;
    assign rd_data  = rsp.rdata;

    a_credit_max: assert property (@(posedge clk) disable iff (!rst)
        credits <= CREDIT_W'(MEM_CREDITS))
        else $error("credit count %0d above queue depth", credits);

    a_req_credit: assert property (@(posedge clk) disable iff (!rst)
        req.valid |-> $past(credits) != '0)
        else $error("request sent with no credit");

endmodule

/* design/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic              clk,
    input  logic              rst,
    output cpu_pkg::mem_req_t mem_req,
    input  cpu_pkg::mem_rsp_t mem_rsp
);
    import cpu_pkg::*;

    logic       issue_fetch;
    logic       issue_data;
    logic       data_we;
    logic       pc_inc;
    logic       pc_load;
    logic       reg_write;
    logic       issued;
    logic       rd_valid;
    logic [7:0] rd_data;
    logic [7:0] pc;
    logic [7:0] store_data;
    insn_u      insn;

    cpu_sequencer i_sequencer (
        .clk         (clk),
        .rst         (rst),
        .issued      (issued),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .issue_fetch (issue_fetch),
        .issue_data  (issue_data),
        .data_we     (data_we),
        .pc_inc      (pc_inc),
        .pc_load     (pc_load),
        .reg_write   (reg_write),
        .insn        (insn)
    );

    program_counter i_pc (
        .clk    (clk),
        .rst    (rst),
        .inc    (pc_inc),
        .load   (pc_load),
        .target (insn.jmp_fmt.target),
        .pc     (pc)
    );

    exec_unit i_exec (
        .clk        (clk),
        .rst        (rst),
        .reg_write  (reg_write),
        .insn       (insn),
        .rd_data    (rd_data),
        .store_data (store_data)
    );

    mem_port i_mem_port (
        .clk         (clk),
        .rst         (rst),
        .issue_fetch (issue_fetch),
        .issue_data  (issue_data),
        .data_we     (data_we),
        .pc          (pc),
        .store_data  (store_data),
        .data_addr   (insn.mem_fmt.addr),
        .rsp         (mem_rsp),
        .req         (mem_req),
        .issued      (issued),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

endmodule

/* testbench/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        image [256],
    input  cpu_pkg::mem_req_t req,
    output cpu_pkg::mem_rsp_t rsp,
    output logic              overflow
);
    import cpu_pkg::*;

    logic [7:0] mem [256];
    mem_req_t   q_req [$];
    int         q_due [$];  // cycle at which each entry may answer
    int         cycle;

    initial begin
        rsp <= '0;
        overflow <= 1'b0;
    end

    always @(posedge clk) begin
        mem_req_t head;
        rsp <= '0;
        overflow <= 1'b0;
        if (!rst) begin
            for (int i = 0; i < 256; i++) mem[8'(i)] = image[8'(i)];
            q_req.delete();
            q_due.delete();
            cycle = 0;
        end else begin
            cycle++;
            if (req.valid) begin
                if (q_req.size() >= MEM_CREDITS) begin
                    overflow <= 1'b1;  // request into a full queue
                end else begin
                    q_req.push_back(req);
                    q_due.push_back(cycle + int'($urandom_range(4, 0)));
                end
            end
            // in order, head only
            if (q_req.size() != 0 && q_due[0] <= cycle) begin
                head = q_req.pop_front();
                void'(q_due.pop_front());
                rsp.credit <= 1'b1;
                if (head.we) begin
                    mem[head.addr] = head.wdata;
                end else begin
                    rsp.valid <= 1'b1;
                    rsp.rdata <= mem[head.addr];
                end
            end
        end
    end

endmodule

/* testbench/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam logic [31:0] SEED = 32'h1288_f2b9;
    localparam int NUM_INSNS = 300;
    localparam int REQ_TIMEOUT = 40;  // cycles
    localparam int JMP_ZONE = 40;     // no jmp above this, so the pc wraps

    logic       clk;
    logic       rst;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    logic       queue_overflow;
    logic [7:0] image [256];
    logic [7:0] ref_mem [256];
    int         req_errors = 0;
    int         data_errors = 0;
    int         protocol_errors = 0;
    int         timeouts = 0;
    int         in_flight = 0;

    cpu_top i_dut (.clk(clk), .rst(rst), .mem_req(mem_req), .mem_rsp(mem_rsp));

    tb_mem_model i_mem (
        .clk(clk), .rst(rst), .image(image), .req(mem_req), .rsp(mem_rsp),
        .overflow(queue_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================
    // stimulus and checks
    // ========================================

    task automatic build_image();
        insn_u w;
        int    pick;
        for (int i = 0; i < 256; i++) begin
            if (i < PROG_WORDS) begin
                pick = int'($urandom_range(15, 0));
                w = '0;
                if (pick == 0 && i < JMP_ZONE) begin
                    w.jmp_fmt.op = op_jmp;
                    w.jmp_fmt.target = 6'($urandom_range(63, 0));
                end else begin
                    w.mem_fmt.op = (pick < 7) ? op_lod : (pick < 11) ? op_str : op_add;
                    w.mem_fmt.reg_sel = 1'($urandom_range(1, 0));
                    w.mem_fmt.addr = 5'($urandom_range(31, 0));
                end
                image[8'(i)] = w;
            end else if (8'(i) >= DATA_BASE) begin
                image[8'(i)] = 8'($urandom_range(255, 0));
            end else begin
                image[8'(i)] = 8'(i) ^ 8'h5a;  // unused gap
            end
            ref_mem[8'(i)] = image[8'(i)];
        end
    endtask

    task automatic next_req(input string what, output mem_req_t r, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        r = '0;
        while (!ok && n < REQ_TIMEOUT) begin
            @(negedge clk);
            if (mem_req.valid === 1'b1) begin
                ok = 1'b1;
                r = mem_req;
            end
            n++;
        end
        if (!ok) $display("timeout at %0t waiting for the %s request", $time, what);
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_req(input mem_req_t got, input mem_req_t exp);
        if (got.we !== exp.we) begin
            req_errors++;
            $display("FAILED at %0t: mem_req.we got %h expected %h", $time, got.we, exp.we);
        end
        if (got.addr !== exp.addr) begin
            req_errors++;
            $display("FAILED at %0t: mem_req.addr got %h expected %h", $time, got.addr, exp.addr);
        end
        if (exp.we) compare_byte("mem_req.wdata", got.wdata, exp.wdata);
    endtask

    // outstanding requests and reset behavior
    always @(negedge clk) begin
        if (!rst) begin
            if (mem_req.valid !== 1'b0) begin
                protocol_errors++;
                $display("request valid during reset at %0t", $time);
            end
            in_flight = 0;
        end else begin
            if (mem_req.valid) in_flight++;
            if (mem_rsp.credit) in_flight--;
            if (in_flight > MEM_CREDITS || in_flight < 0) begin
                protocol_errors++;
                $display("%0d requests outstanding at %0t", in_flight, $time);
            end
            if (queue_overflow) begin
                protocol_errors++;
                $display("memory queue was full when a request arrived at %0t", $time);
            end
        end
    end

    initial begin
        mem_req_t   got;
        mem_req_t   exp;
        insn_u      word;
        bit         ok;
        logic [5:0] ref_pc;
        logic [7:0] ref_a;
        logic [7:0] ref_b;
        logic [7:0] daddr;
        int         n_insn;
        rst <= 1'b0;
        void'($urandom(SEED));
        build_image();
        ref_pc = 6'd0;
        ref_a = 8'd0;
        ref_b = 8'd0;
        n_insn = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;

        while (n_insn < NUM_INSNS && timeouts == 0) begin
            exp = '0;
            exp.valid = 1'b1;
            exp.addr = {2'b00, ref_pc};
            next_req("fetch", got, ok);
            if (!ok) begin
                timeouts++;
                break;
            end
            compare_req(got, exp);
            word = ref_mem[{2'b00, ref_pc}];
            ref_pc = ref_pc + 6'd1;  // wraps at 64
            daddr = DATA_BASE + {3'b000, word.mem_fmt.addr};
            case (word.jmp_fmt.op)
                op_jmp: ref_pc = word.jmp_fmt.target;
                op_add: begin
                    if (word.mem_fmt.reg_sel) ref_b = ref_a + ref_b;
                    else ref_a = ref_a + ref_b;
                end
                default: begin  // lod and str
                    exp = '0;
                    exp.valid = 1'b1;
                    exp.addr = daddr;
                    exp.we = (word.mem_fmt.op == op_str);
                    exp.wdata = word.mem_fmt.reg_sel ? ref_b : ref_a;
                    next_req("data", got, ok);
                    if (!ok) begin
                        timeouts++;
                        break;
                    end
                    compare_req(got, exp);
                    if (exp.we) ref_mem[daddr] = exp.wdata;
                    else if (word.mem_fmt.reg_sel) ref_b = ref_mem[daddr];
                    else ref_a = ref_mem[daddr];
                end
            endcase
            n_insn++;
        end

        $write("instructions %0d, request errors %0d, store data errors %0d, ",
               n_insn, req_errors, data_errors);
        $display("protocol errors %0d, timeouts %0d", protocol_errors, timeouts);
        if (req_errors + data_errors + protocol_errors + timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* build.f */
design/cpu_pkg.sv
design/cpu_sequencer.sv
design/program_counter.sv
design/exec_unit.sv
design/mem_port.sv
design/cpu_top.sv
testbench/tb_mem_model.sv
testbench/tb_cpu.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_cpu -f build.f -o tb_cpu_sim || exit 1

out=$(./obj_dir/tb_cpu_sim)
echo "$out"

echo "$out" | grep -qx "Verification passed" && echo "PASS" || { echo "FAIL"; exit 1; }
